/* build.f */
logic/keypad_pkg.sv
logic/column_scanner.sv
logic/key_debouncer.sv
logic/key_event_encoder.sv
logic/keypad_top.sv
verif/keypad_checker.sv
verif/keypad_tb.sv

/* logic/column_scanner.sv */
`default_nettype none

module column_scanner
    import keypad_pkg::*;
#(
    parameter int SCAN_PERIOD = 8
) (
    input  wire                 clk,
    input  wire                 rst_n,
    input  wire  [num_rows-1:0] row_in,
    output logic [num_cols-1:0] col_out,
    output logic [num_keys-1:0] key_sample,
    output logic                scan_done
);

    localparam int cnt_w = $clog2(SCAN_PERIOD);

    localparam logic [col_w-1:0] last_col = col_w'(num_cols - 1);
    localparam logic [cnt_w-1:0] last_cnt = cnt_w'(SCAN_PERIOD - 1);

    // ==============================
    // Column rotation
    // ==============================

    logic             active;   // Low for the first cycle after reset.
    logic [cnt_w-1:0] dwell_cnt;
    logic [col_w-1:0] col_idx;
    logic             dwell_end;

    assign dwell_end = active && (dwell_cnt == last_cnt);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            active    <= 1'b0;
            dwell_cnt <= '0;
            col_idx   <= '0;
            scan_done <= 1'b0;
        end else begin
            active    <= 1'b1;
            scan_done <= 1'b0;
            if (dwell_end) begin
                dwell_cnt <= '0;
                col_idx   <= col_idx + 1'b1; // Wraps from the last column to 0.
                if (col_idx == last_col) begin
                    scan_done <= 1'b1;
                end
            end else if (active) begin
                dwell_cnt <= dwell_cnt + 1'b1;
            end
        end
    end

    // Only the selected column is pulled low.
    always_comb begin
        col_out = col_idle;
        if (active) begin
            col_out[col_idx] = 1'b0;
        end
    end

    // ==============================
    // Row sampling
    // ==============================

    // Samples of the columns before the last one wait here until the
    // whole scan is complete.
    logic [num_keys-num_rows-1:0] sample_acc;

    always_ff @(posedge clk) begin
        if (dwell_end) begin
            if (col_idx == last_col) begin
                key_sample <= {~row_in, sample_acc};
            end else begin
                sample_acc[col_idx*num_rows +: num_rows] <= ~row_in;
            end
        end
    end

endmodule

`default_nettype wire

/* logic/key_debouncer.sv */
`default_nettype none

module key_debouncer #(
    parameter int DEBOUNCE_SCANS = 3
) (
    input  wire  clk,
    input  wire  rst_n,
    input  wire  sample,
    input  wire  scan_done,
    output logic stable,
    output logic changed
);

    localparam int cnt_w = $clog2(DEBOUNCE_SCANS + 1);

    localparam logic [cnt_w-1:0] accept_cnt = cnt_w'(DEBOUNCE_SCANS - 1);

    // Number of consecutive scans that disagreed with the stable level.
    logic [cnt_w-1:0] mismatch_cnt;
    logic             differs;
    logic             accept;

    assign differs = (sample != stable);
    assign accept  = scan_done && differs && (mismatch_cnt >= accept_cnt);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            stable       <= 1'b0;
            changed      <= 1'b0;
            mismatch_cnt <= '0;
        end else begin
            changed <= accept;
            if (accept) begin
                stable       <= sample;
                mismatch_cnt <= '0;
            end else if (scan_done) begin
                if (!differs) begin
                    mismatch_cnt <= '0; // One agreeing scan is enough to restart.
                end else if (mismatch_cnt < accept_cnt) begin
                    mismatch_cnt <= mismatch_cnt + 1'b1;
                end
            end
        end
    end

endmodule

`default_nettype wire

/* logic/key_event_encoder.sv */
`default_nettype none

module key_event_encoder
    import keypad_pkg::*;
(
    input  wire                 clk,
    input  wire                 rst_n,
    input  wire  [num_keys-1:0] key_stable,
    input  wire  [num_keys-1:0] key_changed,
    output logic                key_event_valid,
    output logic                key_event_pressed,
    output key_code_t           key_event_code
);

    // ==============================
    // Pending flags
    // ==============================

    logic [num_keys-1:0] pending;
    logic [num_keys-1:0] clear_mask;

    // Isolates the lowest set bit, which is the key drained this cycle.
    assign clear_mask = pending & (~pending + 1'b1);

    // A key can change and be drained in the same cycle without either
    // being lost.
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            pending <= '0;
        end else begin
            pending <= (pending & ~clear_mask) | key_changed;
        end
    end

    // ==============================
    // Priority encoder
    // ==============================

    logic [key_w-1:0] first_idx;

    // Scanning from the top leaves the lowest pending index.
    always_comb begin
        first_idx = '0;
        for (int i = num_keys - 1; i >= 0; i--) begin
            if (pending[i]) begin
                first_idx = key_w'(i);
            end
        end
    end

    // ==============================
    // Event outputs
    // ==============================

    always_comb begin
        key_event_valid      = |pending;
        key_event_pressed    = key_stable[first_idx]; // New level of the key.
        key_event_code.index = first_idx;
    end

endmodule

`default_nettype wire

/* logic/keypad_pkg.sv */
`default_nettype none

package keypad_pkg;

    // ==============================
    // Matrix dimensions
    // ==============================

    localparam int num_cols = 4;
    localparam int num_rows = 4;
    localparam int num_keys = num_cols * num_rows;

    localparam int col_w = $clog2(num_cols);
    localparam int row_w = $clog2(num_rows);
    localparam int key_w = col_w + row_w;

    // Column strobe with no column pulled low.
    localparam logic [num_cols-1:0] col_idle = '1;

    // ==============================
    // Key code
    // ==============================

    // The flat index and the position view share one word, so that
    // index = col * num_rows + row holds by construction.
    typedef union packed {
        logic [key_w-1:0] index;
        struct packed {
            logic [col_w-1:0] col; // Upper bits.
            logic [row_w-1:0] row;
        } pos;
    } key_code_t;

endpackage

`default_nettype wire

/* logic/keypad_top.sv */
`default_nettype none

module keypad_top
    import keypad_pkg::*;
#(
    parameter int SCAN_PERIOD    = 8,
    parameter int DEBOUNCE_SCANS = 3
) (
    input  wire                 clk,
    input  wire                 rst_n,
    input  wire  [num_rows-1:0] row_in,
    output logic [num_cols-1:0] col_out,
    output logic [num_keys-1:0] key_state,
    output logic                key_event_valid,
    output logic                key_event_pressed,
    output key_code_t           key_event_code
);

    logic [num_keys-1:0] key_sample;
    logic                scan_done;
    logic [num_keys-1:0] key_stable;
    logic [num_keys-1:0] key_changed;

    column_scanner #(
        .SCAN_PERIOD (SCAN_PERIOD)
    ) u_scanner (
        .clk        (clk),
        .rst_n      (rst_n),
        .row_in     (row_in),
        .col_out    (col_out),
        .key_sample (key_sample),
        .scan_done  (scan_done)
    );

    // One debouncer per key, all stepped by the same scan_done pulse.
    for (genvar i = 0; i < num_keys; i++) begin : g_key
        key_debouncer #(
            .DEBOUNCE_SCANS (DEBOUNCE_SCANS)
        ) u_deb (
            .clk       (clk),
            .rst_n     (rst_n),
            .sample    (key_sample[i]),
            .scan_done (scan_done),
            .stable    (key_stable[i]),
            .changed   (key_changed[i])
        );
    end

    key_event_encoder u_encoder (
        .clk               (clk),
        .rst_n             (rst_n),
        .key_stable        (key_stable),
        .key_changed       (key_changed),
        .key_event_valid   (key_event_valid),
        .key_event_pressed (key_event_pressed),
        .key_event_code    (key_event_code)
    );

    assign key_state = key_stable;

endmodule

`default_nettype wire

/* run.sh */
#!/bin/sh
# Builds the keypad testbench with Verilator, runs it and looks for the pass line in the log.
cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal --top-module keypad_tb -Mdir obj_dir -f build.f \
    && ./obj_dir/Vkeypad_tb > sim.log 2>&1 \
    || { echo "Build or simulation did not complete."; cat sim.log 2>/dev/null; exit 1; }

cat sim.log
grep -q "^=== PASS ===$" sim.log && echo "Result: passed" || { echo "Result: failed"; exit 1; }

/* verif/keypad_checker.sv */
`default_nettype none

module keypad_checker
    import keypad_pkg::*;
#(
    parameter int SCAN_PERIOD    = 8,
    parameter int DEBOUNCE_SCANS = 3
) (
    input  wire                 clk,
    input  wire                 rst_n,
    input  wire  [num_cols-1:0] col_out,
    input  wire  [num_keys-1:0] key_state,
    input  wire                 key_event_valid,
    input  wire                 key_event_pressed,
    input  wire  [key_w-1:0]    key_event_code,
    input  wire  [num_keys-1:0] pressed,
    input  wire                 test_end,
    input  wire  [7:0]          test_num,
    output int                  err_count,
    output int                  tests_done,
    output int                  tests_failed
);

    int                  cyc;          // Cycles since reset was released.
    int                  col;
    int                  test_errs;
    int                  prev_idx;
    int                  mismatch [num_keys];
    logic                prev_valid;
    logic [num_cols-1:0] exp_col;
    logic [num_keys-1:0] raw;          // Rows as the scanner should have seen them.
    logic [num_keys-1:0] model;        // Predicted debounced level.
    logic [num_keys-1:0] state_q1;
    logic [num_keys-1:0] state_q2;
    logic [num_keys-1:0] owed;         // Accepted changes still waiting for their event.
    logic [num_keys-1:0] seen;
    logic [num_keys-1:0] prev_matrix;
    key_code_t           code;

    assign code = key_event_code;

    task automatic report_value(input string what, input logic [31:0] expected,
                                input logic [31:0] actual);
        $display("ERR test_%0d %s expected %0h actual %0h", test_num, what, expected, actual);
        test_errs++;
        err_count++;
    endtask

    task automatic report_text(input string what);
        $display("test_%0d: %s", test_num, what);
        test_errs++;
        err_count++;
    endtask

    // ==============================
    // Reference model
    // ==============================

    task automatic step_debounce();
        for (int k = 0; k < num_keys; k++) begin
            if (raw[k] != model[k]) begin
                mismatch[k]++;
                if (mismatch[k] == DEBOUNCE_SCANS) begin
                    model[k]    = raw[k];
                    owed[k]     = 1'b1;
                    mismatch[k] = 0;
                end
            end else begin
                mismatch[k] = 0;
            end
        end
    endtask

    task automatic check_event();
        int idx;
        int exp_idx;
        idx     = int'(code.index);
        exp_idx = -1;
        // Keys still owed an event are drained lowest first.
        for (int k = 0; k < num_keys; k++) begin
            if (owed[k] && exp_idx < 0) begin
                exp_idx = k;
            end
        end
        if (key_event_valid) begin
            if (exp_idx >= 0 && int'(code.pos.col) != exp_idx / num_rows) begin
                report_value("event column", 32'(exp_idx / num_rows), 32'(code.pos.col));
            end
            if (exp_idx >= 0 && int'(code.pos.row) != exp_idx % num_rows) begin
                report_value("event row", 32'(exp_idx % num_rows), 32'(code.pos.row));
            end
            if (!owed[idx]) begin
                report_text($sformatf("event for key %0d came without an accepted change", idx));
            end else if (key_event_pressed !== model[idx]) begin
                report_value($sformatf("pressed flag of key %0d", idx), 32'(model[idx]),
                             32'(key_event_pressed));
            end
            if (prev_valid && idx <= prev_idx) begin
                report_text($sformatf("key %0d followed key %0d in one burst", idx, prev_idx));
            end
            owed[idx] = 1'b0;
            seen[idx] = 1'b1;
            prev_idx  = idx;
        end
        prev_valid = key_event_valid;
    endtask

    task automatic finish_test();
        if (seen !== (prev_matrix ^ pressed)) begin
            report_value("event set", 32'(prev_matrix ^ pressed), 32'(seen));
        end
        if (key_state !== pressed) begin
            report_value("final key_state", 32'(pressed), 32'(key_state));
        end
        if (owed != '0) begin
            report_text("some accepted changes never produced an event");
        end
        if (test_errs == 0) begin
            $display("test_%0d passed", test_num);
        end else begin
            $display("test_%0d failed with %0d errors", test_num, test_errs);
            tests_failed++;
        end
        tests_done++;
        test_errs   = 0;
        seen        = '0;
        prev_matrix = pressed;
    endtask

    // ==============================
    // Per-cycle comparison
    // ==============================

    always @(posedge clk) begin
        if (!rst_n) begin
            cyc          = 0;
            test_errs    = 0;
            err_count    = 0;
            tests_done   = 0;
            tests_failed = 0;
            prev_valid   = 1'b0;
            prev_idx     = 0;
            raw          = '0;
            model        = '0;
            state_q1     = '0;
            state_q2     = '0;
            owed         = '0;
            seen         = '0;
            prev_matrix  = '0;
            for (int k = 0; k < num_keys; k++) begin
                mismatch[k] = 0;
            end
        end else begin
            exp_col = col_idle; // Idle in the very first cycle.
            if (cyc > 0) begin
                exp_col[((cyc - 1) / SCAN_PERIOD) % num_cols] = 1'b0;
            end
            if (col_out !== exp_col) begin
                report_value("col_out", 32'(exp_col), 32'(col_out));
            end
            if (key_state !== state_q2) begin
                report_value("key_state", 32'(state_q2), 32'(key_state));
            end
            check_event();
            state_q2 = state_q1;
            // Rows are taken in the last cycle of each column's dwell.
            if (cyc > 0 && cyc % SCAN_PERIOD == 0) begin
                col = (cyc / SCAN_PERIOD - 1) % num_cols;
                raw[col*num_rows +: num_rows] = pressed[col*num_rows +: num_rows];
                if (col == num_cols - 1) begin
                    step_debounce();
                end
            end
            state_q1 = model;
            if (test_end) begin
                finish_test();
            end
            cyc++;
        end
    end

endmodule

`default_nettype wire

/* verif/keypad_tb.sv */
`default_nettype none

module keypad_tb
    import keypad_pkg::*;
();

    localparam int SCAN_PERIOD    = 8;
    localparam int DEBOUNCE_SCANS = 3;
    localparam int num_tests      = 10;
    localparam int scans_per_test = 12;
    localparam int scan_cycles    = num_cols * SCAN_PERIOD;
    localparam int test_cycles    = scans_per_test * scan_cycles;
    localparam int max_cycles     = num_tests * scans_per_test * scan_cycles + 200;

    logic                clk;
    logic                rst_n;
    logic [num_rows-1:0] row_in;
    logic [num_cols-1:0] col_out;
    logic [num_keys-1:0] key_state;
    logic                key_event_valid;
    logic                key_event_pressed;
    key_code_t           key_event_code;

    logic [num_keys-1:0] pressed;   // Keys held down on the modeled keypad.
    logic                test_end;
    logic [7:0]          test_num;
    logic [31:0]         seed;
    int                  cycles = 0;
    int                  err_count;
    int                  tests_done;
    int                  tests_failed;

    initial clk = 1'b0;
    always #5 clk = ~clk;

    // ==============================
    // DUT and checker
    // ==============================

    keypad_top #(
        .SCAN_PERIOD    (SCAN_PERIOD),
        .DEBOUNCE_SCANS (DEBOUNCE_SCANS)
    ) u_dut (
        .clk               (clk),
        .rst_n             (rst_n),
        .row_in            (row_in),
        .col_out           (col_out),
        .key_state         (key_state),
        .key_event_valid   (key_event_valid),
        .key_event_pressed (key_event_pressed),
        .key_event_code    (key_event_code)
    );

    keypad_checker #(
        .SCAN_PERIOD    (SCAN_PERIOD),
        .DEBOUNCE_SCANS (DEBOUNCE_SCANS)
    ) u_chk (
        .clk               (clk),
        .rst_n             (rst_n),
        .col_out           (col_out),
        .key_state         (key_state),
        .key_event_valid   (key_event_valid),
        .key_event_pressed (key_event_pressed),
        .key_event_code    (key_event_code),
        .pressed           (pressed),
        .test_end          (test_end),
        .test_num          (test_num),
        .err_count         (err_count),
        .tests_done        (tests_done),
        .tests_failed      (tests_failed)
    );

    // A pressed key shorts its row to the column that is driven low.
    always_comb begin
        row_in = '1;
        for (int c = 0; c < num_cols; c++) begin
            for (int r = 0; r < num_rows; r++) begin
                if (!col_out[c] && pressed[c*num_rows + r]) begin
                    row_in[r] = 1'b0;
                end
            end
        end
    end

    // ==============================
    // Stimulus
    // ==============================

    function automatic logic [31:0] next_random(input logic [31:0] state);
        return state * 32'd1664525 + 32'd1013904223;
    endfunction

    task automatic draw(output logic [15:0] value);
        seed  = next_random(seed);
        value = seed[31:16]; // Upper half has the longer period.
    endtask

    initial begin
        logic [15:0] base;
        logic [15:0] mask_a;
        logic [15:0] mask_b;
        logic [15:0] pick;
        logic [15:0] glitch;
        int          glitch_from;
        int          glitch_len;
        rst_n    = 1'b0;
        pressed  = '0;
        test_end = 1'b0;
        test_num = '0;
        seed     = 32'hd6e5;
        repeat (10) @(negedge clk);
        rst_n = 1'b1;
        for (int t = 0; t < num_tests; t++) begin
            draw(base);
            draw(mask_a);
            draw(mask_b);
            draw(pick);
            glitch      = mask_a & mask_b;
            glitch_from = 0;
            glitch_len  = 0;
            if (pick[1:0] == 2'd1) begin
                glitch_len = scan_cycles; // One scan right at the change.
            end else if (pick[1:0] >= 2'd2) begin
                glitch_from = 5 * scan_cycles + int'(pick[7:2]);
                glitch_len  = (1 + int'(pick[10:8]) % (DEBOUNCE_SCANS - 1)) * scan_cycles;
            end
            test_num = 8'(t);
            for (int c = 0; c < test_cycles; c++) begin
                if (c >= glitch_from && c < glitch_from + glitch_len) begin
                    pressed = base ^ glitch;
                end else begin
                    pressed = base;
                end
                test_end = (c == test_cycles - 1);
                @(negedge clk);
            end
        end
        test_end = 1'b0;
        repeat (2) @(negedge clk);
        $display("Tests run: %0d, failed: %0d, errors: %0d", tests_done, tests_failed, err_count);
        if (err_count == 0 && tests_done == num_tests) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

    always @(posedge clk) begin
        cycles = cycles + 1;
        if (cycles >= max_cycles) begin
            $display("Timeout: the run did not finish within %0d cycles.", max_cycles);
            $display("=== FAIL ===");
            $finish;
        end
    end

endmodule

`default_nettype wire
